// File: fetch_fifo.sv
// instruction FIFO
`timescale 1ns/100ps

module fetch_fifo #(
  parameter int FIFO_DEPTH  = 2,
  parameter int ALM_FULL_TH = 1
) (
  input  logic    clk,
  input  logic    rst_n,
  fifo_if.storage fifo
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // entry storage
  fetch_pkg::fifo_entry_t mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic do_push;
  logic do_pop;

  // pointer wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // status and head
  ////////////////////////////////////////////////////////////////////////////

  assign fifo.empty    = (count_q == '0);
  assign fifo.full     = (count_q == CNT_W'(FIFO_DEPTH));
  // new fetches stop once this many entries are waiting
  assign fifo.alm_full = (count_q >= CNT_W'(ALM_FULL_TH));
  // head comes from storage only, no fall-through of push_data
  assign fifo.pop_data = mem_q[rd_ptr_q];

  // flush cancels both sides of the cycle
  assign do_push = fifo.push & ~fifo.full & ~fifo.flush;
  assign do_pop  = fifo.pop & ~fifo.empty & ~fifo.flush;

  ////////////////////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (fifo.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload write
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= fifo.push_data;
    end
  end

  // decode consumption may only take an entry that is really stored
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    fifo.pop |-> !fifo.empty)
    else $error("fetch_fifo: pop while empty");

endmodule

// File: fetch_pkg.sv
// instruction fetch shared types
package fetch_pkg;

  // byte address of an instruction fetch
  typedef logic [31:0] addr_t;

  // raw instruction word as returned by memory
  typedef logic [31:0] word_t;

  // one buffered fetch
  // data sits in the upper half, its address in the lower half
  typedef struct packed {
    word_t data;
    addr_t addr;
  } fifo_entry_t;

  // fetch FSM states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_JUMP
  } fetch_state_e;

  // executable region, base inclusive, limit exclusive
  localparam addr_t DEF_PMP_BASE  = 32'h0000_0000;
  localparam addr_t DEF_PMP_LIMIT = 32'h0001_0000;

endpackage

// File: fetch_pmp_check.sv
// fetch permission check
`timescale 1ns/100ps

module fetch_pmp_check #(
  parameter fetch_pkg::addr_t PMP_BASE  = fetch_pkg::DEF_PMP_BASE,
  parameter fetch_pkg::addr_t PMP_LIMIT = fetch_pkg::DEF_PMP_LIMIT
) (
  input  logic             req_i,
  input  fetch_pkg::addr_t addr_i,
  output logic             err_o
);

  // word address actually fetched
  fetch_pkg::addr_t word_addr;
  logic             in_region;

  // one region match, base inclusive and limit exclusive
  // more regions would OR further hits into in_region
  function automatic logic region_hit(
    input fetch_pkg::addr_t addr,
    input fetch_pkg::addr_t base,
    input fetch_pkg::addr_t limit
  );
    return (addr >= base) && (addr < limit);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // region compare
  ////////////////////////////////////////////////////////////////////////////

  assign word_addr = {addr_i[31:2], 2'b00};

  assign in_region = region_hit(word_addr, PMP_BASE, PMP_LIMIT);

  // only a driven request can fault
  // result goes to next-state logic only, never back into the request
  assign err_o = req_i & ~in_region;

endmodule

// File: fetch_unit.sv
// instruction fetch unit
`timescale 1ns/100ps

module fetch_unit #(
  parameter int               FIFO_DEPTH  = 2,
  parameter int               ALM_FULL_TH = 1,
  parameter fetch_pkg::addr_t PMP_BASE    = fetch_pkg::DEF_PMP_BASE,
  parameter fetch_pkg::addr_t PMP_LIMIT   = fetch_pkg::DEF_PMP_LIMIT
) (
  input  logic             clk,
  input  logic             rst_n,
  // core control
  input  logic             req_i,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  // decode handshake
  input  logic             ready_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o,
  // instruction memory bus
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  output fetch_pkg::addr_t instr_addr_o,
  input  fetch_pkg::word_t instr_rdata_i,
  input  logic             instr_rvalid_i,
  // status
  output logic             fetch_failed_o,
  output logic             busy_o
);

  // permission fault on the request of this cycle
  logic err_pmp;

  prefetch_buffer #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .ALM_FULL_TH (ALM_FULL_TH)
  ) u_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .err_pmp_i      (err_pmp),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

  // checks the address as it goes out on the bus
  fetch_pmp_check #(
    .PMP_BASE  (PMP_BASE),
    .PMP_LIMIT (PMP_LIMIT)
  ) u_fetch_pmp_check (
    .req_i  (instr_req_o),
    .addr_i (instr_addr_o),
    .err_o  (err_pmp)
  );

endmodule

// File: fifo_if.sv
// prefetch to instruction FIFO link
`timescale 1ns/100ps

interface fifo_if;

  // write side, one entry per accepted push
  logic                   push;
  fetch_pkg::fifo_entry_t push_data;
  // read side, head is always visible on pop_data
  logic                   pop;
  fetch_pkg::fifo_entry_t pop_data;
  // drops all stored entries, wins over push
  logic                   flush;
  // fill status
  logic                   empty;
  logic                   full;
  logic                   alm_full;

  // prefetch buffer side
  modport producer (
    output push, push_data, pop, flush,
    input  pop_data, empty, full, alm_full
  );

  // FIFO side
  modport storage (
    input  push, push_data, pop, flush,
    output pop_data, empty, full, alm_full
  );

endinterface

// File: list.f
fetch_pkg.sv
fifo_if.sv
fetch_fifo.sv
prefetch_buffer.sv
fetch_pmp_check.sv
fetch_unit.sv
tb_instr_mem.sv
tb_fetch_unit.sv

// File: prefetch_buffer.sv
// instruction prefetch buffer
`timescale 1ns/100ps

module prefetch_buffer #(
  parameter int FIFO_DEPTH  = 2,
  parameter int ALM_FULL_TH = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  // core side
  input  logic             req_i,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             ready_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o,
  // instruction memory
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  output fetch_pkg::addr_t instr_addr_o,
  input  fetch_pkg::word_t instr_rdata_i,
  input  logic             instr_rvalid_i,
  // permission check and status
  input  logic             err_pmp_i,
  output logic             fetch_failed_o,
  output logic             busy_o
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;

  // address of the outstanding fetch
  fetch_pkg::addr_t instr_addr_q;
  fetch_pkg::addr_t fetch_addr;
  logic             addr_valid;

  // a faulting request was granted and its response is still due
  logic fault_rsp_q;

  logic fifo_valid;
  logic fifo_ready;
  logic fifo_push;
  logic rsp_bypass;

  fifo_if instr_fifo ();

  // state after a request is driven
  // a faulting fetch still completes on the bus, its data is dropped
  function automatic fetch_pkg::fetch_state_e issue_next(input logic gnt, input logic err);
    if (!gnt) begin
      return fetch_pkg::WAIT_GNT;
    end
    if (err) begin
      return fetch_pkg::WAIT_JUMP;
    end
    return fetch_pkg::WAIT_RVALID;
  endfunction

  assign busy_o = (state_q != fetch_pkg::IDLE) | instr_req_o;

  // next sequential word
  assign fetch_addr = {instr_addr_q[31:2], 2'b00} + 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    instr_req_o    = 1'b0;
    instr_addr_o   = fetch_addr;
    addr_valid     = 1'b0;
    fifo_push      = 1'b0;
    fetch_failed_o = 1'b0;

    unique case (state_q)
      // nothing outstanding
      fetch_pkg::IDLE: begin
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
        end
        if (req_i && (fifo_ready || branch_i)) begin
          instr_req_o = 1'b1;
          addr_valid  = 1'b1;
          state_d     = issue_next(instr_gnt_i, err_pmp_i);
        end
      end

      // request held until granted
      fetch_pkg::WAIT_GNT: begin
        instr_req_o  = 1'b1;
        instr_addr_o = instr_addr_q;
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
          addr_valid   = 1'b1;
        end
        state_d = issue_next(instr_gnt_i, err_pmp_i);
      end

      // granted, response pending
      fetch_pkg::WAIT_RVALID: begin
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
        end
        if (req_i && (fifo_ready || branch_i)) begin
          if (instr_rvalid_i) begin
            // next request goes out with this response
            instr_req_o = 1'b1;
            addr_valid  = 1'b1;
            fifo_push   = fifo_valid | ~ready_i;
            state_d     = issue_next(instr_gnt_i, err_pmp_i);
          end else if (branch_i) begin
            // keep the target, old response still has to drain
            addr_valid = 1'b1;
            state_d    = fetch_pkg::WAIT_ABORTED;
          end
        end else if (instr_rvalid_i) begin
          fifo_push = fifo_valid | ~ready_i;
          state_d   = fetch_pkg::IDLE;
        end
      end

      // stale response pending, redirect target already in instr_addr_q
      fetch_pkg::WAIT_ABORTED: begin
        instr_addr_o = instr_addr_q;
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
          addr_valid   = 1'b1;
        end
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = issue_next(instr_gnt_i, err_pmp_i);
        end
      end

      // permission fault, only a branch gets us out
      fetch_pkg::WAIT_JUMP: begin
        fetch_failed_o = ~valid_o;
        if (branch_i) begin
          instr_addr_o   = branch_addr_i;
          addr_valid     = 1'b1;
          fetch_failed_o = 1'b0;
          if (fault_rsp_q && !instr_rvalid_i) begin
            state_d = fetch_pkg::WAIT_ABORTED;
          end else begin
            instr_req_o = 1'b1;
            state_d     = issue_next(instr_gnt_i, err_pmp_i);
          end
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::IDLE;
      instr_addr_q <= '0;
      fault_rsp_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (addr_valid) begin
        instr_addr_q <= instr_addr_o;
      end
      // a new faulting grant takes priority over a returning response
      if (instr_req_o && instr_gnt_i && err_pmp_i) begin
        fault_rsp_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        fault_rsp_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction FIFO and output select
  ////////////////////////////////////////////////////////////////////////////

  fetch_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .ALM_FULL_TH (ALM_FULL_TH)
  ) u_fetch_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .fifo  (instr_fifo)
  );

  assign fifo_valid = ~instr_fifo.empty;
  assign fifo_ready = ~(instr_fifo.alm_full | instr_fifo.full);

  // only a response to a live fetch may skip the FIFO
  assign rsp_bypass = instr_rvalid_i & (state_q == fetch_pkg::WAIT_RVALID);

  assign instr_fifo.push      = fifo_push;
  assign instr_fifo.push_data = '{data: instr_rdata_i, addr: instr_addr_q};
  assign instr_fifo.pop       = valid_o & ready_i & fifo_valid;
  assign instr_fifo.flush     = branch_i;

  // head of FIFO first, else the response in flight
  // nothing is offered in a branch cycle, it is all pre-branch
  always_comb begin
    if (fifo_valid) begin
      valid_o = ~branch_i;
      rdata_o = instr_fifo.pop_data.data;
      addr_o  = instr_fifo.pop_data.addr;
    end else begin
      valid_o = rsp_bypass & ~branch_i;
      rdata_o = instr_rdata_i;
      addr_o  = instr_addr_q;
    end
  end

  // bus rule, an ungranted request stays put until granted or redirected
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=>
      (branch_i || (instr_req_o && $stable(instr_addr_o))))
    else $error("prefetch_buffer: request dropped or changed before grant");

  // request throttling must leave room for every outstanding response
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    instr_fifo.push |-> !instr_fifo.full)
    else $error("prefetch_buffer: push into full FIFO");

endmodule

// File: run.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch_unit -f list.f

# the simulator exits non-zero on a failed check, the log decides the result
./obj_dir/Vtb_fetch_unit > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb_fetch_unit.sv
// fetch unit testbench
`timescale 1ns/100ps

module tb_fetch_unit;

  localparam fetch_pkg::addr_t PMP_LIMIT = 32'h0000_0400;
  localparam fetch_pkg::word_t DATA_MASK = 32'hA5A5_0000;
  localparam int unsigned      SEED      = 32'h16db7e6f;

  logic             clk;
  logic             rst_n;
  logic             req_i;
  logic             branch_i;
  fetch_pkg::addr_t branch_addr_i;
  logic             ready_i;
  logic             valid_o;
  fetch_pkg::word_t rdata_o;
  fetch_pkg::addr_t addr_o;
  logic             instr_req_o;
  logic             instr_gnt_i;
  fetch_pkg::addr_t instr_addr_o;
  fetch_pkg::word_t instr_rdata_i;
  logic             instr_rvalid_i;
  logic             fetch_failed_o;
  logic             busy_o;
  logic             mem_overlap;

  // reference model state
  fetch_pkg::addr_t exp_addr;
  fetch_pkg::addr_t branch_target;
  fetch_pkg::addr_t hold_addr;
  fetch_pkg::word_t hold_data;
  logic             after_branch;
  logic             failed_q;
  logic             busy_q;
  logic             consume;
  int               consumed;
  int               errors     = 0;
  int               ready_left = 0;

  fetch_unit #(
    .FIFO_DEPTH  (2),
    .ALM_FULL_TH (1),
    .PMP_BASE    (32'h0000_0000),
    .PMP_LIMIT   (PMP_LIMIT)
  ) UUT (.*);

  tb_instr_mem u_instr_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (instr_req_o),
    .addr_i    (instr_addr_o),
    .gnt_o     (instr_gnt_i),
    .rvalid_o  (instr_rvalid_i),
    .rdata_o   (instr_rdata_i),
    .overlap_o (mem_overlap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign consume = valid_o & ready_i;

  // expected address moves by a word per item, jumps on a branch
  always @(posedge clk) begin
    failed_q  <= fetch_failed_o;
    busy_q    <= busy_o;
    hold_addr <= addr_o;
    hold_data <= rdata_o;
    if (!rst_n) begin
      consumed     <= 0;
      after_branch <= 1'b0;
    end else if (branch_i) begin
      exp_addr      <= branch_addr_i;
      branch_target <= branch_addr_i;
      after_branch  <= 1'b1;
    end else if (consume) begin
      exp_addr     <= exp_addr + 32'd4;
      consumed     <= consumed + 1;
      after_branch <= 1'b0;
    end
  end

  task automatic stop_failed();
    errors++;
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first failing check");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    stop_failed();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> ({instr_req_o, valid_o, fetch_failed_o, busy_o} == 4'b0000))
    else report_mismatch("reset_idle", 0,
      32'($sampled({instr_req_o, valid_o, fetch_failed_o, busy_o})));
  a_idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (UUT.u_prefetch_buffer.state_q == fetch_pkg::IDLE && !req_i) |-> !busy_o)
    else report_mismatch("idle_not_busy", 0, 32'($sampled(busy_o)));
  a_seq_addr: assert property (@(posedge clk) disable iff (!rst_n)
    consume |-> (addr_o == exp_addr))
    else report_mismatch("seq_addr", $sampled(exp_addr), $sampled(addr_o));
  a_seq_data: assert property (@(posedge clk) disable iff (!rst_n)
    consume |-> (rdata_o == (addr_o ^ DATA_MASK)))
    else report_mismatch("seq_data", $sampled(addr_o) ^ DATA_MASK, $sampled(rdata_o));
  // a stalled item may only go away through a branch
  a_hold_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_o && !ready_i) |=> (branch_i || (valid_o && addr_o == hold_addr)))
    else report_mismatch("hold_addr", $sampled(hold_addr), $sampled(addr_o));
  a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_o && !ready_i) |=> (branch_i || rdata_o == hold_data))
    else report_mismatch("hold_data", $sampled(hold_data), $sampled(rdata_o));
  a_branch_first: assert property (@(posedge clk) disable iff (!rst_n)
    (consume && after_branch) |-> (addr_o == branch_target))
    else report_mismatch("branch_first", $sampled(branch_target), $sampled(addr_o));
  a_pmp_bound: assert property (@(posedge clk) disable iff (!rst_n)
    consume |-> (addr_o < PMP_LIMIT))
    else report_mismatch("pmp_bound", PMP_LIMIT, $sampled(addr_o));
  a_fail_clear: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |=> !fetch_failed_o)
    else report_mismatch("fail_clear", 0, 32'($sampled(fetch_failed_o)));
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    !mem_overlap)
    else report_mismatch("one_outstanding", 0, 32'($sampled(mem_overlap)));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // decode stalls come in long stretches
  task automatic step_cycle();
    @(negedge clk);
    branch_i = 1'b0;
    if (ready_left == 0) begin
      ready_i    = ~ready_i;
      ready_left = ready_i ? int'($urandom_range(1, 8)) : int'($urandom_range(4, 16));
    end else begin
      ready_left--;
    end
  endtask

  task automatic send_branch(input fetch_pkg::addr_t target);
    step_cycle();
    branch_i      = 1'b1;
    branch_addr_i = target;
  endtask

  task automatic wait_items(input int count, input int limit, input string label);
    int target;
    int cycles;
    target = consumed + count;
    cycles = 0;
    while (consumed < target) begin
      if (cycles >= limit) begin
        $display("timeout while waiting for %s", label);
        stop_failed();
      end
      step_cycle();
      cycles++;
    end
  endtask

  // level 1 waits for fetch_failed_o high, level 0 for busy_o low
  task automatic wait_status(input logic level, input int limit, input string label);
    int cycles;
    cycles = 0;
    while (level ? !failed_q : busy_q) begin
      if (cycles >= limit) begin
        $display("timeout while waiting for %s", label);
        stop_failed();
      end
      step_cycle();
      cycles++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    ready_i       = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) step_cycle();
    // fetching starts with a jump to address zero
    send_branch('0);
    req_i = 1'b1;
    wait_items(40, 2000, "sequential fetch");
    // branches land at random points of a fetch
    repeat (16) begin
      repeat ($urandom_range(0, 12)) step_cycle();
      send_branch(fetch_pkg::addr_t'($urandom_range(0, 160) << 2));
      wait_items(3, 400, "fetch after branch");
    end
    // run off the end of the executable region
    send_branch(PMP_LIMIT - 32'd32);
    wait_status(1'b1, 600, "fetch_failed_o to rise");
    repeat (6) step_cycle();
    send_branch(32'h0000_0100);
    wait_items(10, 1000, "fetch after fault recovery");
    step_cycle();
    req_i = 1'b0;
    wait_status(1'b0, 400, "busy_o to drop");
    repeat (10) step_cycle();
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tb_instr_mem.sv
// instruction memory model
`timescale 1ns/100ps

module tb_instr_mem (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  fetch_pkg::addr_t addr_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output fetch_pkg::word_t rdata_o,
  output logic             overlap_o
);

  // every word is its own address with the upper half scrambled
  localparam fetch_pkg::word_t DATA_MASK = 32'hA5A5_0000;

  // grant side
  logic             gnt_en     = 1'b0;
  int               gnt_wait   = 0;
  logic             acc_q      = 1'b0;
  fetch_pkg::addr_t acc_addr_q = '0;
  // response side
  logic             pend       = 1'b0;
  fetch_pkg::addr_t pend_addr  = '0;
  int               rsp_wait   = 0;
  logic             rvalid_q   = 1'b0;
  fetch_pkg::word_t rdata_q    = '0;
  logic             overlap_q  = 1'b0;

  // grant follows the request once the random wait has run out
  assign gnt_o     = req_i & gnt_en;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign overlap_o = overlap_q;

  // acceptance is seen on the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      acc_q    <= 1'b0;
      gnt_wait <= 0;
    end else if (req_i && gnt_o) begin
      acc_q      <= 1'b1;
      acc_addr_q <= addr_i;
      // delay for the next grant, 0 to 3 cycles
      gnt_wait   <= $urandom_range(0, 3);
    end else begin
      acc_q <= 1'b0;
      if (req_i && gnt_wait > 0) begin
        gnt_wait <= gnt_wait - 1;
      end
    end
  end

  // bus inputs of the DUT change on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      gnt_en    <= 1'b0;
      rvalid_q  <= 1'b0;
      overlap_q <= 1'b0;
      pend      = 1'b0;
    end else begin
      gnt_en   <= (gnt_wait == 0);
      rvalid_q <= 1'b0;
      if (acc_q) begin
        // a second grant before the first response is a bus error
        if (pend) begin
          overlap_q <= 1'b1;
        end
        pend      = 1'b1;
        pend_addr = acc_addr_q;
        rsp_wait  = $urandom_range(0, 2);
      end
      // response 1 to 3 cycles after the grant
      if (pend) begin
        if (rsp_wait == 0) begin
          rvalid_q <= 1'b1;
          rdata_q  <= pend_addr ^ DATA_MASK;
          pend     = 1'b0;
        end else begin
          rsp_wait = rsp_wait - 1;
        end
      end
    end
  end

endmodule
